// ==== flist.f ====
+incdir+.
st7735_pkg.sv
st7735_init_seq.sv
st7735_pixel_port.sv
st7735_stream_mux.sv
st7735_spi_tx.sv
st7735_ctrl.sv
tb_st7735.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ST7735 testbench with Verilator and runs it.
# Exit status is 0 only when the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_st7735 -f flist.f -o tb_st7735_sim \
   && ./obj_dir/tb_st7735_sim | tee /dev/stderr | grep -q "=== PASS ===" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== st7735_ctrl.sv ====
`timescale 1ns/1ps
/*
 * ST7735 panel controller top level. A host writes pixels over Wishbone;
 * the controller resets and configures the panel, then streams frames.
 */
module st7735_ctrl #(
   parameter int CLK_DIV      = 2,
   parameter int MS_CYCLES    = 12000,
   parameter int RESET_CYCLES = 120000,
   parameter int FRAME_PIXELS = 12800  // 160 x 80
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  st7735_pkg::wb_req_t   wb_req,
   output st7735_pkg::wb_rsp_t   wb_rsp,
   output st7735_pkg::lcd_pins_t lcd
);
   import st7735_pkg::*;

   lcd_item_t init_item;
   lcd_item_t link_item;
   pixel_t    pix;
   logic      init_valid, init_ready, init_done, lcd_rst;
   logic      pix_valid, pix_ready;
   logic      link_valid, link_ready;
   logic      spi_clk, mosi, dc, cs;

   st7735_init_seq #(.RESET_CYCLES(RESET_CYCLES)) u_init (
      .clk, .rst_n, .item(init_item), .item_valid(init_valid), .item_ready(init_ready),
      .init_done, .lcd_rst
   );

   st7735_pixel_port u_port (
      .clk, .rst_n, .wb_req, .wb_rsp, .init_done, .pix, .pix_valid, .pix_ready
   );

   st7735_stream_mux #(.FRAME_PIXELS(FRAME_PIXELS)) u_mux (
      .clk, .rst_n, .init_item, .init_valid, .init_ready, .init_done,
      .pix, .pix_valid, .pix_ready,
      .out_item(link_item), .out_valid(link_valid), .out_ready(link_ready)
   );

   st7735_spi_tx #(.CLK_DIV(CLK_DIV), .MS_CYCLES(MS_CYCLES)) u_spi (
      .clk, .rst_n, .item(link_item), .item_valid(link_valid), .item_ready(link_ready),
      .spi_clk, .mosi, .dc, .cs
   );

   assign lcd = '{spi_clk: spi_clk, mosi: mosi, dc: dc, cs: cs, rst: lcd_rst};

endmodule

// ==== st7735_init_seq.sv ====
`timescale 1ns/1ps
/*
 * Start-up sequencer. Holds the panel reset pin low for RESET_CYCLES after
 * rst_n, then offers the start-up command table one entry at a time and
 * raises init_done once the last entry has been taken.
 */
module st7735_init_seq #(
   parameter int RESET_CYCLES = 120000
) (
   input  logic                  clk,
   input  logic                  rst_n,
   output st7735_pkg::lcd_item_t item,
   output logic                  item_valid,
   input  logic                  item_ready,
   output logic                  init_done,
   output logic                  lcd_rst
);
   import st7735_pkg::*;

   localparam int RW = $clog2(RESET_CYCLES + 1);
   localparam int IW = $clog2(INIT_LEN);

   logic [RW-1:0] rst_cnt;  // panel reset hold time
   logic [IW-1:0] idx;      // current table entry

   // panel reset pulse, starts counting when rst_n is released
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rst_cnt <= '0;
         lcd_rst <= 1'b0;
      end else if (!lcd_rst) begin
         rst_cnt <= rst_cnt + 1'b1;
         if (rst_cnt == RW'(RESET_CYCLES - 1)) begin
            lcd_rst <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idx       <= '0;
         init_done <= 1'b0;
      end else if (item_valid && item_ready) begin
         if (idx == IW'(INIT_LEN - 1)) begin
            init_done <= 1'b1;  // sticky until the next rst_n
         end else begin
            idx <= idx + 1'b1;
         end
      end
   end

   assign item       = INIT_TABLE[idx];
   assign item_valid = lcd_rst && !init_done;  // panel must be out of reset

   // no command reaches the link while the panel is still in reset
   a_no_item_in_reset: assert property (
      @(posedge clk) disable iff (!rst_n)
      !lcd_rst |-> !item_valid
   ) else $error("init item offered while panel reset is low");

   // once the table is done the frame loop owns the link for good
   a_init_done_sticky: assert property (
      @(posedge clk) disable iff (!rst_n)
      init_done |=> init_done
   ) else $error("init_done fell");

endmodule

// ==== st7735_pixel_port.sv ====
`timescale 1ns/1ps
/*
 * Wishbone classic slave holding one pending pixel. Writes are acked only
 * while the buffer is free, which is the host's only back-pressure. Reads
 * return the status word with init_done and buffer_free.
 */
module st7735_pixel_port (
   input  logic                clk,
   input  logic                rst_n,
   input  st7735_pkg::wb_req_t wb_req,
   output st7735_pkg::wb_rsp_t wb_rsp,
   input  logic                init_done,
   output st7735_pkg::pixel_t  pix,
   output logic                pix_valid,
   input  logic                pix_ready
);
   import st7735_pkg::*;

   pixel_t pix_q;   // pending pixel
   logic   full;
   logic   ack;
   logic   req;     // new request, not the one being acked
   logic   wr_ok;

   assign req   = wb_req.cyc && wb_req.stb && !ack;
   assign wr_ok = req && wb_req.we && !full;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack  <= 1'b0;
         full <= 1'b0;
      end else begin
         ack <= wr_ok || (req && !wb_req.we);  // writes wait for a free buffer
         if (wr_ok) begin
            full <= 1'b1;
         end else if (pix_valid && pix_ready) begin
            full <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         pix_q <= wb_req.dat;
      end
   end

   assign wb_rsp    = '{ack: ack, dat: {14'd0, ~full, init_done}};
   assign pix       = pix_q;
   assign pix_valid = full;

   // every ack answers a request held on the cycle before
   a_ack_needs_req: assert property (
      @(posedge clk) disable iff (!rst_n)
      ack |-> $past(wb_req.cyc && wb_req.stb)
   ) else $error("ack without a bus request");

   a_ack_single: assert property (
      @(posedge clk) disable iff (!rst_n)
      ack |=> !ack
   ) else $error("ack high on two cycles in a row");

endmodule

// ==== st7735_pkg.sv ====
/*
 * Shared types and command tables for the ST7735 SPI panel controller.
 * Every RTL block imports what it needs from here, and so does the testbench.
 */
package st7735_pkg;

   typedef logic [15:0] pixel_t;  // one RGB565 pixel
   typedef logic [7:0]  cmd_t;    // command or parameter byte

   typedef struct packed {
      logic [15:0] data;     // byte items use the low 8 bits
      logic        dc;       // 0 command, 1 data
      logic        wide;     // 16-bit pixel word
      logic [8:0]  wait_ms;  // cs-high time after the item
   } lcd_item_t;

   typedef struct packed {
      logic   cyc;
      logic   stb;
      logic   we;
      pixel_t dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [15:0] dat;  // bit 0 init_done, bit 1 buffer_free
   } wb_rsp_t;

   typedef struct packed {
      logic spi_clk;
      logic mosi;
      logic dc;
      logic cs;
      logic rst;
   } lcd_pins_t;

   localparam cmd_t CMD_RAMWR = 8'h2C;
   localparam int   INIT_LEN  = 23;
   localparam int   HDR_LEN   = 11;

   // narrow command byte, optional post-command wait
   function automatic lcd_item_t cmd_b(cmd_t b, logic [8:0] ms = 9'd0);
      return {8'h00, b, 1'b0, 1'b0, ms};
   endfunction

   function automatic lcd_item_t par_b(cmd_t b);  // narrow parameter byte
      return {8'h00, b, 1'b1, 1'b0, 9'd0};
   endfunction

   // one command with its parameters per line
   localparam lcd_item_t INIT_TABLE [0:INIT_LEN-1] = '{
      cmd_b(8'h01, 9'd150),                                    // SWRESET
      cmd_b(8'h11, 9'd255),                                    // SLPOUT
      cmd_b(8'hB4), par_b(8'h07),                              // INVCTR
      cmd_b(8'hC0), par_b(8'hA2), par_b(8'h02), par_b(8'h84),  // PWCTR1
      cmd_b(8'hC3), par_b(8'h8A), par_b(8'h2A),                // PWCTR4
      cmd_b(8'hC4), par_b(8'h8A), par_b(8'hEE),                // PWCTR5
      cmd_b(8'hC5), par_b(8'h0E),                              // VMCTR1
      cmd_b(8'h20),                                            // INVOFF
      cmd_b(8'h36), par_b(8'hC8),                              // MADCTL
      cmd_b(8'h3A), par_b(8'h05),                              // COLMOD, 16 bit/pixel
      cmd_b(8'h13, 9'd10),                                     // NORON
      cmd_b(8'h29, 9'd100)                                     // DISPON
   };

   // column window 0..79, row window 0..159, then memory write
   localparam lcd_item_t HDR_TABLE [0:HDR_LEN-1] = '{
      cmd_b(8'h2A), par_b(8'h00), par_b(8'h00), par_b(8'h00), par_b(8'h4F),
      cmd_b(8'h2B), par_b(8'h00), par_b(8'h00), par_b(8'h00), par_b(8'h9F),
      cmd_b(CMD_RAMWR)
   };

endpackage

// ==== st7735_spi_tx.sv ====
`timescale 1ns/1ps
/*
 * SPI serializer for the panel link. Each accepted item becomes one cs-low
 * burst, MSB first, 8 or 16 bits; spi_clk idles high and mosi changes on its
 * falling edge. cs then stays high for the item's wait before the next item.
 */
module st7735_spi_tx #(
   parameter int CLK_DIV   = 2,
   parameter int MS_CYCLES = 12000
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  st7735_pkg::lcd_item_t item,
   input  logic                  item_valid,
   output logic                  item_ready,
   output logic                  spi_clk,
   output logic                  mosi,
   output logic                  dc,
   output logic                  cs
);
   localparam int DW = $clog2(CLK_DIV + 1);
   localparam int WW = $clog2(2 * CLK_DIV + 511 * MS_CYCLES + 1);

   typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_WAIT} state_t;

   state_t        state;
   logic [DW-1:0] div_cnt;   // half-period divider
   logic [4:0]    bit_cnt;   // bits left, current one included
   logic [15:0]   shreg;     // bit 15 is on mosi
   logic [WW-1:0] wait_cnt;  // cs-high cycles left
   logic          half;
   logic          accept;
   logic          fall;      // spi_clk falls onto the next bit

   assign item_ready = (state == S_IDLE);
   assign accept     = item_valid && item_ready;
   assign half       = (div_cnt == DW'(CLK_DIV - 1));
   assign fall       = (state == S_SHIFT) && half && spi_clk && (bit_cnt != 5'd1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         div_cnt  <= '0;
         bit_cnt  <= '0;
         wait_cnt <= '0;
         spi_clk  <= 1'b1;
         mosi     <= 1'b0;
         dc       <= 1'b0;
         cs       <= 1'b1;
      end else begin
         case (state)
            S_IDLE: if (accept) begin
               state    <= S_SHIFT;
               cs       <= 1'b0;
               spi_clk  <= 1'b0;  // first falling edge
               dc       <= item.dc;
               mosi     <= item.wide ? item.data[15] : item.data[7];
               bit_cnt  <= item.wide ? 5'd16 : 5'd8;
               div_cnt  <= '0;
               // post-burst gap plus the command's wait, counted down to zero
               wait_cnt <= WW'(item.wait_ms) * WW'(MS_CYCLES) + WW'(2 * CLK_DIV - 1);
            end
            S_SHIFT: begin
               div_cnt <= half ? '0 : div_cnt + 1'b1;
               if (half && !spi_clk) begin
                  spi_clk <= 1'b1;  // panel samples here
               end else if (fall) begin
                  spi_clk <= 1'b0;
                  mosi    <= shreg[14];
                  bit_cnt <= bit_cnt - 1'b1;
               end else if (half) begin
                  state <= S_WAIT;  // last bit done
                  cs    <= 1'b1;
               end
            end
            S_WAIT: begin
               if (wait_cnt == '0) begin
                  state <= S_IDLE;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         shreg <= item.wide ? item.data : {item.data[7:0], 8'h00};
      end else if (fall) begin
         shreg <= {shreg[14:0], 1'b0};
      end
   end

   // the panel latches dc per byte, so it must hold through a burst
   a_dc_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      (!cs && $past(!cs)) |-> $stable(dc)
   ) else $error("dc changed inside a cs-low burst");

endmodule

// ==== st7735_stream_mux.sv ====
`timescale 1ns/1ps
/*
 * Merges the start-up items and the frame loop into one registered stream.
 * Before init_done it forwards start-up items; afterwards it repeats the
 * window header followed by FRAME_PIXELS wide data items built from pixels.
 */
module st7735_stream_mux #(
   parameter int FRAME_PIXELS = 12800
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  st7735_pkg::lcd_item_t init_item,
   input  logic                  init_valid,
   output logic                  init_ready,
   input  logic                  init_done,
   input  st7735_pkg::pixel_t    pix,
   input  logic                  pix_valid,
   output logic                  pix_ready,
   output st7735_pkg::lcd_item_t out_item,
   output logic                  out_valid,
   input  logic                  out_ready
);
   import st7735_pkg::*;

   localparam int HW = $clog2(HDR_LEN);
   localparam int PW = $clog2(FRAME_PIXELS + 1);

   typedef enum logic [1:0] {PH_INIT, PH_HDR, PH_PIX} phase_t;

   phase_t    phase;
   logic [HW-1:0] hdr_idx;
   logic [PW-1:0] pix_cnt;   // pixels sent in this frame
   logic      slot_free;     // output register empty or draining
   logic      load;
   lcd_item_t nxt;

   assign slot_free  = !out_valid || out_ready;
   assign init_ready = (phase == PH_INIT) && slot_free;
   assign pix_ready  = (phase == PH_PIX) && slot_free;

   always_comb begin
      load = 1'b0;
      nxt  = init_item;
      case (phase)
         PH_INIT: load = init_valid && slot_free;
         PH_HDR: begin
            load = slot_free;
            nxt  = HDR_TABLE[hdr_idx];
         end
         PH_PIX: begin
            load = pix_valid && slot_free;
            nxt  = '{data: pix, dc: 1'b1, wide: 1'b1, wait_ms: 9'd0};
         end
         default: load = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase     <= PH_INIT;
         hdr_idx   <= '0;
         pix_cnt   <= '0;
         out_valid <= 1'b0;
      end else begin
         if (load) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
         case (phase)
            PH_INIT: if (init_done) phase <= PH_HDR;
            PH_HDR: if (load) begin
               hdr_idx <= (hdr_idx == HW'(HDR_LEN - 1)) ? '0 : hdr_idx + 1'b1;
               if (hdr_idx == HW'(HDR_LEN - 1)) phase <= PH_PIX;
            end
            PH_PIX: if (load) begin
               pix_cnt <= (pix_cnt == PW'(FRAME_PIXELS - 1)) ? '0 : pix_cnt + 1'b1;
               if (pix_cnt == PW'(FRAME_PIXELS - 1)) phase <= PH_HDR;  // next frame
            end
            default: phase <= PH_INIT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         out_item <= nxt;
      end
   end

   // a stalled item is held unchanged until the serializer takes it
   a_out_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_item))
   ) else $error("out_item changed while stalled");

endmodule

// ==== tb_st7735_checks.svh ====
/*
 * Wishbone bus tasks, typed compare tasks and the pixel generator for the
 * ST7735 testbench. Included inside the testbench module body.
 */

int unsigned lcg_state = 10759;

// next pseudo-random RGB565 pixel
function automatic pixel_t lcg_pixel();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state[31:16];
endfunction

// one classic write, held until the slave acks
task automatic wb_write(input pixel_t value);
   wb_req = wb_req_t'{cyc: 1'b1, stb: 1'b1, we: 1'b1, dat: value};
   @(negedge clk);
   while (!wb_rsp.ack) @(negedge clk);
   wb_req = '0;
endtask

task automatic wb_read(output wb_rsp_t rsp);
   wb_req = wb_req_t'{cyc: 1'b1, stb: 1'b1, we: 1'b0, dat: 16'h0000};
   @(negedge clk);
   while (!wb_rsp.ack) @(negedge clk);
   rsp    = wb_rsp;  // sampled on the ack cycle
   wb_req = '0;
endtask

task automatic cmp_item(input string what, input lcd_item_t exp, input burst_t got);
   logic [15:0] exp_val;
   int          exp_bits;
   exp_bits = exp.wide ? 16 : 8;
   exp_val  = exp.wide ? exp.data : {8'h00, exp.data[7:0]};
   checks++;
   if (got.bits != exp_bits || got.item.data !== exp_val || got.item.dc !== exp.dc) begin
      errors++;
      $display("ERROR t=%0t %s: exp data %h dc %b bits %0d, got data %h dc %b bits %0d",
               $time, what, exp_val, exp.dc, exp_bits, got.item.data, got.item.dc, got.bits);
   end
endtask

task automatic cmp_status(input string what, input wb_rsp_t exp, input wb_rsp_t got,
                          input logic [15:0] mask);
   checks++;
   if (got.ack !== exp.ack || ((got.dat ^ exp.dat) & mask) !== 16'h0000) begin
      errors++;
      $display("ERROR t=%0t %s: exp ack %b dat %h, got ack %b dat %h (mask %h)",
               $time, what, exp.ack, exp.dat, got.ack, got.dat, mask);
   end
endtask

task automatic cmp_gap(input string what, input int min_cycles, input int got);
   checks++;
   if (got < min_cycles) begin
      errors++;
      $display("ERROR t=%0t %s: exp >= %0d cycles, got %0d", $time, what, min_cycles, got);
   end
endtask

task automatic cmp_count(input string what, input int exp, input int got);
   checks++;
   if (got != exp) begin
      errors++;
      $display("ERROR t=%0t %s: exp %0d, got %0d", $time, what, exp, got);
   end
endtask

task automatic cmp_pins(input string what, input lcd_pins_t exp, input lcd_pins_t got,
                        input lcd_pins_t mask);
   checks++;
   if (((exp ^ got) & mask) !== 5'b00000) begin
      errors++;
      $display("ERROR t=%0t %s: exp %b, got %b (mask %b)", $time, what, exp, got, mask);
   end
endtask

// ==== tb_st7735.sv ====
`timescale 1ns/1ps
/*
 * Testbench for the ST7735 controller. Runs the DUT with short timings, logs
 * every cs-low burst on the SPI link and checks start-up, frames and the host port.
 */
module tb_st7735;
   import st7735_pkg::*;

   localparam int CLK_DIV      = 2;
   localparam int MS_CYCLES    = 20;
   localparam int RESET_CYCLES = 40;
   localparam int FRAME_PIXELS = 4;
   localparam int CLK_PERIOD   = 8;
   localparam int RESET_HOLD   = 16;
   localparam int NUM_PIX      = 8;
   localparam int MIN_GAP      = 2 * CLK_DIV;
   localparam int NARROW_CYC   = 10 * 2 * CLK_DIV;  // 8 bits plus gap and slack
   localparam int WIDE_CYC     = 18 * 2 * CLK_DIV;
   localparam int FRAME_CYC    = HDR_LEN * NARROW_CYC + FRAME_PIXELS * WIDE_CYC;

   // dc in bit 8 above the byte
   localparam logic [11:0] INIT_EXP [0:INIT_LEN-1] = '{
      12'h001, 12'h011, 12'h0B4, 12'h107, 12'h0C0, 12'h1A2, 12'h102, 12'h184,
      12'h0C3, 12'h18A, 12'h12A, 12'h0C4, 12'h18A, 12'h1EE, 12'h0C5, 12'h10E,
      12'h020, 12'h036, 12'h1C8, 12'h03A, 12'h105, 12'h013, 12'h029
   };
   localparam logic [11:0] HDR_EXP [0:HDR_LEN-1] = '{
      12'h02A, 12'h100, 12'h100, 12'h100, 12'h14F,
      12'h02B, 12'h100, 12'h100, 12'h100, 12'h19F, 12'h02C
   };
   localparam lcd_pins_t PINS_RESET = '{spi_clk: 1'b1, mosi: 1'b0, dc: 1'b0, cs: 1'b1, rst: 1'b0};
   localparam lcd_pins_t PINS_MASK  = '{spi_clk: 1'b1, mosi: 1'b0, dc: 1'b0, cs: 1'b1, rst: 1'b1};

   typedef struct {
      lcd_item_t item;  // data and dc as seen on the pins
      int        bits;
      int        gap;   // cs-high cycles before this burst
   } burst_t;

   logic      clk = 1'b0;
   logic      rst_n;
   wb_req_t   wb_req;
   wb_rsp_t   wb_rsp;
   lcd_pins_t lcd;

   int        errors = 0;
   int        checks = 0;
   burst_t    bursts [$];
   burst_t    init_seen [0:INIT_LEN-1];
   pixel_t    exp_pix [0:NUM_PIX-1];
   time       release_time;
   time       last_end = 0;

   `include "tb_st7735_checks.svh"

   st7735_ctrl #(
      .CLK_DIV(CLK_DIV), .MS_CYCLES(MS_CYCLES),
      .RESET_CYCLES(RESET_CYCLES), .FRAME_PIXELS(FRAME_PIXELS)
   ) DUT (
      .clk, .rst_n, .wb_req, .wb_rsp, .lcd
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // one record per cs-low burst
   always begin : spi_monitor
      burst_t b;
      @(negedge lcd.cs);
      b.gap  = int'(($time - last_end) / CLK_PERIOD);
      b.item = '0;
      b.bits = 0;
      @(posedge lcd.spi_clk or posedge lcd.cs);
      while (!lcd.cs) begin
         b.item.data = {b.item.data[14:0], lcd.mosi};  // MSB first
         b.item.dc   = lcd.dc;
         b.bits      = b.bits + 1;
         @(posedge lcd.spi_clk or posedge lcd.cs);
      end
      b.item.wide = (b.bits == 16);
      bursts.push_back(b);
      last_end = $time;
   end

   function automatic lcd_item_t narrow_item(logic [11:0] code, int ms);
      return '{data: {8'h00, code[7:0]}, dc: code[8], wide: 1'b0, wait_ms: 9'(ms)};
   endfunction

   function automatic int init_wait_ms(int idx);
      case (idx)
         0:       return 150;  // SWRESET
         1:       return 255;  // SLPOUT
         21:      return 10;   // NORON
         22:      return 100;  // DISPON
         default: return 0;
      endcase
   endfunction

   task automatic next_burst(output burst_t b);
      while (bursts.size() == 0) @(negedge clk);
      b = bursts.pop_front();
   endtask

   task automatic reset_pins_and_status();
      wb_rsp_t rsp;
      cmp_pins("pins after reset", PINS_RESET, lcd, PINS_MASK);
      wb_read(rsp);
      cmp_status("status in reset", wb_rsp_t'{ack: 1'b1, dat: 16'h0002}, rsp, 16'hFFFF);
      while (!lcd.rst) @(negedge clk);
      cmp_count("panel reset cycles", RESET_CYCLES, int'(($time - release_time) / CLK_PERIOD));
   endtask

   task automatic queue_pixels_under_stall();
      wb_rsp_t rsp;
      for (int i = 0; i < NUM_PIX; i++) begin
         exp_pix[i] = lcg_pixel();
      end
      wb_write(exp_pix[0]);  // start-up still owns the link, so this pixel stays put
      wb_read(rsp);
      cmp_status("status with pixel pending", wb_rsp_t'{ack: 1'b1, dat: 16'h0000}, rsp, 16'hFFFF);
      for (int i = 1; i < NUM_PIX; i++) begin
         wb_write(exp_pix[i]);  // each one waits for the buffer to drain
      end
   endtask

   task automatic init_table_bursts();
      burst_t b;
      for (int i = 0; i < INIT_LEN; i++) begin
         next_burst(b);
         init_seen[i] = b;
         cmp_item($sformatf("start-up burst %0d", i), narrow_item(INIT_EXP[i], 0), b);
      end
   endtask

   task automatic post_command_waits();
      for (int i = 1; i < INIT_LEN; i++) begin
         cmp_gap($sformatf("gap before start-up burst %0d", i),
                 init_wait_ms(i - 1) * MS_CYCLES + MIN_GAP, init_seen[i].gap);
      end
   endtask

   // lead_ms is the wait of the item just before the header
   task automatic check_header(input int lead_ms);
      burst_t b;
      for (int i = 0; i < HDR_LEN; i++) begin
         next_burst(b);
         cmp_item($sformatf("header burst %0d", i), narrow_item(HDR_EXP[i], 0), b);
         cmp_gap($sformatf("gap before header burst %0d", i),
                 (i == 0 ? lead_ms * MS_CYCLES : 0) + MIN_GAP, b.gap);
      end
   endtask

   task automatic header_after_startup();
      wb_rsp_t rsp;
      wb_read(rsp);
      cmp_status("init_done after start-up", wb_rsp_t'{ack: 1'b1, dat: 16'h0001}, rsp, 16'h0001);
      check_header(init_wait_ms(INIT_LEN - 1));
   endtask

   task automatic pixel_frames();
      burst_t    b;
      lcd_item_t exp;
      wb_rsp_t   rsp;
      for (int i = 0; i < NUM_PIX; i++) begin
         if (i != 0 && i % FRAME_PIXELS == 0) begin
            check_header(0);  // next frame
         end
         exp = '{data: exp_pix[i], dc: 1'b1, wide: 1'b1, wait_ms: 9'd0};
         next_burst(b);
         cmp_item($sformatf("pixel burst %0d", i), exp, b);
         cmp_gap($sformatf("gap before pixel burst %0d", i), MIN_GAP, b.gap);
      end
      wb_read(rsp);
      cmp_status("status after frames", wb_rsp_t'{ack: 1'b1, dat: 16'h0003}, rsp, 16'hFFFF);
   endtask

   initial begin
      rst_n  = 1'b0;
      wb_req = '0;
      repeat (RESET_HOLD) @(negedge clk);
      rst_n        = 1'b1;
      release_time = $time;
      reset_pins_and_status();
      queue_pixels_under_stall();
      init_table_bursts();
      post_command_waits();
      header_after_startup();
      pixel_frames();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // half again over reset, start-up waits and three frames of bursts
   initial begin
      int wait_ms;
      int limit;
      wait_ms = 0;
      for (int i = 0; i < INIT_LEN; i++) begin
         wait_ms += init_wait_ms(i);
      end
      limit = (RESET_HOLD + RESET_CYCLES + wait_ms * MS_CYCLES + INIT_LEN * NARROW_CYC
               + 3 * FRAME_CYC) * 3 / 2;
      #(limit * CLK_PERIOD);
      $display("timeout: run still going after %0d clock cycles, %0d errors", limit, errors);
      $display("=== FAIL ===");
      $finish;
   end

endmodule
